//--- common/calc_defs.svh
`ifndef CALC_DEFS_SVH
`define CALC_DEFS_SVH

// operand and accumulator width
`define CALC_DATA_W 16

// opcode width, enough for eight operations
`define CALC_OP_W 3

// command word, opcode sits above the operand
`define CALC_CMD_W (`CALC_OP_W + `CALC_DATA_W)

// input side buffers more commands than results
`define CALC_IN_DEPTH 8

// output fifo depth
`define CALC_OUT_DEPTH 4

`endif

//--- common/calc_pkg.sv
`include "calc_defs.svh"

package calc_pkg;

    // command opcodes, encoding is fixed by the command format
    typedef enum logic [`CALC_OP_W-1:0] {
        OP_LOAD  = 3'd0,
        OP_ADD   = 3'd1,
        OP_SUB   = 3'd2,
        OP_AND   = 3'd3,
        OP_OR    = 3'd4,
        OP_XOR   = 3'd5,
        OP_CLEAR = 3'd6,
        OP_EMIT  = 3'd7
    } calc_op_e;

    // controller states
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_EXEC = 2'd1,
        ST_PUSH = 2'd2
    } calc_state_e;

endpackage

//--- rtl/fifo/fifo_mod.sv
`timescale 1ns/1ps

module fifo_mod #(
    parameter int data_width = 16,
    parameter int depth      = 8
)
(
    input  logic                  clk_i,
    input  logic                  arst_ni,

    // write side
    input  logic [data_width-1:0] din_i,
    input  logic                  din_val_i,
    output logic                  din_rdy_o,

    // read side, fall-through
    output logic [data_width-1:0] dout_o,
    output logic                  dout_val_o,
    input  logic                  dout_rdy_i
);

    localparam int addr_w = $clog2(depth);
    localparam logic [addr_w-1:0] last_addr = addr_w'(depth - 1);

    logic [data_width-1:0] mem [depth];

    // one extra msb tells full from empty
    logic [addr_w:0] wr_ptr;
    logic [addr_w:0] rd_ptr;
    logic            full;
    logic            empty;
    logic            wr_en;
    logic            rd_en;

    // wrap at depth, flipping the lap bit
    function automatic logic [addr_w:0] ptr_next(input logic [addr_w:0] ptr);
        logic [addr_w:0] nxt;
        if (ptr[addr_w-1:0] == last_addr)
        begin
            nxt = {~ptr[addr_w], {addr_w{1'b0}}};
        end
        else
        begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[addr_w] != rd_ptr[addr_w]) &&
                   (wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]);

    assign din_rdy_o  = !full;
    assign dout_val_o = !empty;

    assign wr_en = din_val_i && !full;
    assign rd_en = dout_rdy_i && !empty;

    always_ff @(posedge clk_i or negedge arst_ni)
    begin
        if (!arst_ni)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (wr_en)
            begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (rd_en)
            begin
                rd_ptr <= ptr_next(rd_ptr);
            end
        end
    end

    // storage, no reset needed
    always_ff @(posedge clk_i)
    begin
        if (wr_en)
        begin
            mem[wr_ptr[addr_w-1:0]] <= din_i;
        end
    end

    // combinational read at the head
    assign dout_o = mem[rd_ptr[addr_w-1:0]];

endmodule

//--- rtl/calc_acc_unit.sv
`timescale 1ns/1ps

`include "calc_defs.svh"

module calc_acc_unit
    import calc_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    arst_ni,

    input  calc_op_e                op_i,
    input  logic [`CALC_DATA_W-1:0] operand_i,
    input  logic                    acc_en_i,

    output logic [`CALC_DATA_W-1:0] acc_o
);

    logic [`CALC_DATA_W-1:0] acc_q;
    logic [`CALC_DATA_W-1:0] acc_d;

    // next value, add and sub wrap at the data width
    always_comb
    begin
        case (op_i)
            OP_LOAD:
            begin
                acc_d = operand_i;
            end
            OP_ADD:
            begin
                acc_d = acc_q + operand_i;
            end
            OP_SUB:
            begin
                acc_d = acc_q - operand_i;
            end
            OP_AND:
            begin
                acc_d = acc_q & operand_i;
            end
            OP_OR:
            begin
                acc_d = acc_q | operand_i;
            end
            OP_XOR:
            begin
                acc_d = acc_q ^ operand_i;
            end
            OP_CLEAR:
            begin
                acc_d = '0;
            end
            default:
            begin
                // emit leaves the value for the output path
                acc_d = acc_q;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_ni)
    begin
        if (!arst_ni)
        begin
            acc_q <= '0;
        end
        else if (acc_en_i)
        begin
            acc_q <= acc_d;
        end
    end

    assign acc_o = acc_q;

endmodule

//--- rtl/calc_ctrl.sv
`timescale 1ns/1ps

`include "calc_defs.svh"

module calc_ctrl
    import calc_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   arst_ni,

    // command side
    input  logic [`CALC_CMD_W-1:0] cmd_i,
    input  logic                   cmd_val_i,
    output logic                   cmd_pop_o,

    // accumulator control
    output calc_op_e               op_o,
    output logic [`CALC_DATA_W-1:0] operand_o,
    output logic                   acc_en_o,

    // result side
    output logic                   res_push_o,
    input  logic                   res_rdy_i
);

    calc_state_e state_q;
    calc_state_e state_d;

    // latched command
    calc_op_e                op_q;
    logic [`CALC_DATA_W-1:0] operand_q;

    logic pop;
    logic is_emit;

    // only pop while idle, a new command is then latched
    assign pop     = (state_q == ST_IDLE) && cmd_val_i;
    assign is_emit = (op_q == OP_EMIT);

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:
            begin
                if (pop)
                begin
                    state_d = ST_EXEC;
                end
            end
            ST_EXEC:
            begin
                // emit needs the output fifo, everything else is one cycle
                if (is_emit)
                begin
                    state_d = ST_PUSH;
                end
                else
                begin
                    state_d = ST_IDLE;
                end
            end
            ST_PUSH:
            begin
                if (res_rdy_i)
                begin
                    state_d = ST_IDLE;
                end
            end
            default:
            begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_ni)
    begin
        if (!arst_ni)
        begin
            state_q <= ST_IDLE;
            op_q    <= OP_LOAD;
        end
        else
        begin
            state_q <= state_d;
            if (pop)
            begin
                op_q <= calc_op_e'(cmd_i[`CALC_CMD_W-1 -: `CALC_OP_W]);
            end
        end
    end

    // operand is payload
    always_ff @(posedge clk_i)
    begin
        if (pop)
        begin
            operand_q <= cmd_i[`CALC_DATA_W-1:0];
        end
    end

    assign cmd_pop_o  = pop;
    assign op_o       = op_q;
    assign operand_o  = operand_q;
    assign acc_en_o   = (state_q == ST_EXEC) && !is_emit;

    // held until the output fifo takes the word
    assign res_push_o = (state_q == ST_PUSH);

endmodule

//--- rtl/stream_calc_top.sv
`timescale 1ns/1ps

`include "calc_defs.svh"

module stream_calc_top
    import calc_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    arst_ni,

    // command stream in
    input  logic [`CALC_CMD_W-1:0]  cmd_i,
    input  logic                    cmd_val_i,
    output logic                    cmd_rdy_o,

    // result stream out
    output logic [`CALC_DATA_W-1:0] res_o,
    output logic                    res_val_o,
    input  logic                    res_rdy_i
);

    // input fifo to controller
    logic [`CALC_CMD_W-1:0]  cmd_word;
    logic                    cmd_val;
    logic                    cmd_pop;

    // controller to accumulator
    calc_op_e                op;
    logic [`CALC_DATA_W-1:0] operand;
    logic                    acc_en;
    logic [`CALC_DATA_W-1:0] acc;

    // controller to output fifo
    logic                    res_push;
    logic                    res_rdy;

    fifo_mod #(
        .data_width (`CALC_CMD_W),
        .depth      (`CALC_IN_DEPTH)
    ) u_in_fifo (
        .clk_i      (clk_i),
        .arst_ni    (arst_ni),
        .din_i      (cmd_i),
        .din_val_i  (cmd_val_i),
        .din_rdy_o  (cmd_rdy_o),
        .dout_o     (cmd_word),
        .dout_val_o (cmd_val),
        .dout_rdy_i (cmd_pop)
    );

    calc_ctrl u_ctrl (
        .clk_i      (clk_i),
        .arst_ni    (arst_ni),
        .cmd_i      (cmd_word),
        .cmd_val_i  (cmd_val),
        .cmd_pop_o  (cmd_pop),
        .op_o       (op),
        .operand_o  (operand),
        .acc_en_o   (acc_en),
        .res_push_o (res_push),
        .res_rdy_i  (res_rdy)
    );

    calc_acc_unit u_acc (
        .clk_i      (clk_i),
        .arst_ni    (arst_ni),
        .op_i       (op),
        .operand_i  (operand),
        .acc_en_i   (acc_en),
        .acc_o      (acc)
    );

    // accumulator value is the write data, no extra register
    fifo_mod #(
        .data_width (`CALC_DATA_W),
        .depth      (`CALC_OUT_DEPTH)
    ) u_out_fifo (
        .clk_i      (clk_i),
        .arst_ni    (arst_ni),
        .din_i      (acc),
        .din_val_i  (res_push),
        .din_rdy_o  (res_rdy),
        .dout_o     (res_o),
        .dout_val_o (res_val_o),
        .dout_rdy_i (res_rdy_i)
    );

endmodule

//--- test/stream_calc_props.sv
`timescale 1ns/1ps

`include "calc_defs.svh"

module stream_calc_props
    import calc_pkg::*;
#(
    parameter int in_ptr_w  = $clog2(`CALC_IN_DEPTH) + 1,
    parameter int out_ptr_w = $clog2(`CALC_OUT_DEPTH) + 1
)
(
    input logic                    clk_i,
    input logic                    arst_ni,
    input logic                    cmd_val_i,
    input logic                    cmd_pop_i,
    input logic [`CALC_DATA_W-1:0] res_i,
    input logic                    res_val_i,
    input logic                    res_rdy_i,
    input logic                    in_val_i,
    input logic                    in_rdy_i,
    input logic [in_ptr_w-1:0]     in_wr_ptr_i,
    input logic                    out_val_i,
    input logic                    out_rdy_i,
    input logic [out_ptr_w-1:0]    out_wr_ptr_i,
    input calc_state_e             state_i
);

    // read by the testbench for its final verdict
    int prop_failures;

    initial
    begin
        prop_failures = 0;
    end

    // pop only when the input fifo has a word
    pop_needs_valid: assert property (@(posedge clk_i) disable iff (!arst_ni)
        cmd_pop_i |-> cmd_val_i)
    else
    begin
        $error("controller popped while the input fifo was empty");
        prop_failures++;
    end

    // head of the output fifo holds while stalled
    res_stable: assert property (@(posedge clk_i) disable iff (!arst_ni)
        (res_val_i && !res_rdy_i) |=> $stable(res_i))
    else
    begin
        $error("res_o changed while res_val_o was high and res_rdy_i low");
        prop_failures++;
    end

    in_no_full_write: assert property (@(posedge clk_i) disable iff (!arst_ni)
        (in_val_i && !in_rdy_i) |=> $stable(in_wr_ptr_i))
    else
    begin
        $error("input fifo took a write while full");
        prop_failures++;
    end

    out_no_full_write: assert property (@(posedge clk_i) disable iff (!arst_ni)
        (out_val_i && !out_rdy_i) |=> $stable(out_wr_ptr_i))
    else
    begin
        $error("output fifo took a write while full");
        prop_failures++;
    end

    state_legal: assert property (@(posedge clk_i) disable iff (!arst_ni)
        state_i inside {ST_IDLE, ST_EXEC, ST_PUSH})
    else
    begin
        $error("controller state left the legal set");
        prop_failures++;
    end

endmodule

bind stream_calc_top stream_calc_props u_props (
    .clk_i        (clk_i),
    .arst_ni      (arst_ni),
    .cmd_val_i    (cmd_val),
    .cmd_pop_i    (cmd_pop),
    .res_i        (res_o),
    .res_val_i    (res_val_o),
    .res_rdy_i    (res_rdy_i),
    .in_val_i     (cmd_val_i),
    .in_rdy_i     (cmd_rdy_o),
    .in_wr_ptr_i  (u_in_fifo.wr_ptr),
    .out_val_i    (res_push),
    .out_rdy_i    (res_rdy),
    .out_wr_ptr_i (u_out_fifo.wr_ptr),
    .state_i      (u_ctrl.state_q)
);

//--- test/tb_stream_calc.sv
`timescale 1ns/1ps

`include "calc_defs.svh"

module tb_stream_calc
    import calc_pkg::*;
();

    localparam int cmd_timeout   = 200;
    localparam int drain_timeout = 4000;

    logic                    clk_i;
    logic                    arst_ni;
    logic [`CALC_CMD_W-1:0]  cmd_i;
    logic                    cmd_val_i;
    logic                    cmd_rdy_o;
    logic [`CALC_DATA_W-1:0] res_o;
    logic                    res_val_o;
    logic                    res_rdy_i;

    integer                  seed;
    logic [`CALC_DATA_W-1:0] model_acc;
    logic [`CALC_DATA_W-1:0] exp_q [$];
    int                      errors;
    int                      results;
    int                      emits;
    int                      tests_run;
    int                      tests_failed;
    int                      err_base;
    int                      emit_base;
    int                      res_base;
    // 0 ready, 1 held low, 2 random
    int                      rdy_mode;

    stream_calc_top dut0 (
        .clk_i     (clk_i),
        .arst_ni   (arst_ni),
        .cmd_i     (cmd_i),
        .cmd_val_i (cmd_val_i),
        .cmd_rdy_o (cmd_rdy_o),
        .res_o     (res_o),
        .res_val_o (res_val_o),
        .res_rdy_i (res_rdy_i)
    );

    always #5 clk_i = ~clk_i;

    // next accumulator value, add and sub taken modulo 2^16
    function automatic logic [`CALC_DATA_W-1:0] calc_model(
        input calc_op_e                op,
        input logic [`CALC_DATA_W-1:0] operand,
        input logic [`CALC_DATA_W-1:0] acc
    );
        logic [`CALC_DATA_W-1:0] res;
        case (op)
            OP_LOAD:  res = operand;
            OP_ADD:   res = 16'((int'(acc) + int'(operand)) % 65536);
            OP_SUB:   res = 16'((int'(acc) + 65536 - int'(operand)) % 65536);
            OP_AND:   res = acc & operand;
            OP_OR:    res = acc | operand;
            OP_XOR:   res = acc ^ operand;
            OP_CLEAR: res = '0;
            default:  res = acc;
        endcase
        return res;
    endfunction

    function automatic int total_errors();
        return errors + dut0.u_props.prop_failures;
    endfunction

    always @(posedge clk_i)
    begin
        case (rdy_mode)
            0:       res_rdy_i <= 1'b1;
            1:       res_rdy_i <= 1'b0;
            default: res_rdy_i <= (($random(seed) % 3) != 0);
        endcase
    end

    // result monitor
    always @(posedge clk_i)
    begin
        logic [`CALC_DATA_W-1:0] exp_val;
        if (arst_ni && res_val_o && res_rdy_i)
        begin
            results++;
            assert (exp_q.size() > 0)
            else
            begin
                $display("result %h at %0t arrived with no emit outstanding", res_o, $time);
                errors++;
            end
            if (exp_q.size() > 0)
            begin
                exp_val = exp_q.pop_front();
                assert (res_o == exp_val)
                else
                begin
                    $display("ERROR at %0t: res_o expected %h actual %h", $time, exp_val, res_o);
                    errors++;
                end
            end
        end
    end

    task automatic send_cmd(input calc_op_e op, input logic [`CALC_DATA_W-1:0] operand);
        int waited;
        waited = 0;
        cmd_i     <= {op, operand};
        cmd_val_i <= 1'b1;
        do
        begin
            @(posedge clk_i);
            waited++;
        end
        while (!cmd_rdy_o && waited < cmd_timeout);
        if (!cmd_rdy_o)
        begin
            $display("timeout: %s command not accepted after %0d cycles", op.name(), waited);
            errors++;
        end
        else if (op == OP_EMIT)
        begin
            exp_q.push_back(model_acc);
            emits++;
        end
        else
        begin
            model_acc = calc_model(op, operand, model_acc);
        end
    endtask

    task automatic idle(input int cycles);
        cmd_val_i <= 1'b0;
        repeat (cycles) @(posedge clk_i);
    endtask

    task automatic start_test();
        err_base  = total_errors();
        emit_base = emits;
        res_base  = results;
    endtask

    task automatic finish_test(input string name);
        int waited;
        waited = 0;
        cmd_val_i <= 1'b0;
        while (exp_q.size() != 0 && waited < drain_timeout)
        begin
            @(posedge clk_i);
            waited++;
        end
        if (exp_q.size() != 0)
        begin
            $display("timeout: %0d results still missing in %s", exp_q.size(), name);
            errors++;
        end
        // room for any extra result to show up
        repeat (20) @(posedge clk_i);
        assert (results - res_base == emits - emit_base)
        else
        begin
            $display("%s got %0d results for %0d emits", name,
                     results - res_base, emits - emit_base);
            errors++;
        end
        tests_run++;
        if (total_errors() == err_base)
        begin
            $display("[%0t] %s: ok", $time, name);
        end
        else
        begin
            tests_failed++;
            $display("[%0t] %s: FAILED, %0d errors", $time, name, total_errors() - err_base);
        end
    endtask

    initial
    begin
        int filled;
        clk_i        = 1'b0;
        arst_ni      = 1'b0;
        cmd_i        = '0;
        cmd_val_i    = 1'b0;
        res_rdy_i    = 1'b0;
        seed         = 32'h61502d37;
        model_acc    = '0;
        errors       = 0;
        results      = 0;
        emits        = 0;
        tests_run    = 0;
        tests_failed = 0;
        rdy_mode     = 0;
        filled       = 0;
        repeat (8) @(posedge clk_i);
        arst_ni <= 1'b1;
        @(posedge clk_i);

        start_test();
        assert (cmd_rdy_o === 1'b1)
        else
        begin
            $display("ERROR at %0t: cmd_rdy_o expected 1 actual %b", $time, cmd_rdy_o);
            errors++;
        end
        assert (res_val_o === 1'b0)
        else
        begin
            $display("ERROR at %0t: res_val_o expected 0 actual %b", $time, res_val_o);
            errors++;
        end
        send_cmd(OP_EMIT, '0);
        finish_test("reset and first emit");

        start_test();
        send_cmd(OP_LOAD, 16'h1234);
        send_cmd(OP_EMIT, '0);
        for (int k = 1; k <= 6; k++)
        begin
            send_cmd(calc_op_e'(3'(k)), 16'($random(seed)));
            send_cmd(OP_EMIT, '0);
        end
        // wrap in both directions
        send_cmd(OP_LOAD, 16'hfff0);
        send_cmd(OP_ADD, 16'h0025);
        send_cmd(OP_EMIT, '0);
        send_cmd(OP_SUB, 16'h0100);
        send_cmd(OP_EMIT, '0);
        finish_test("single operations");

        start_test();
        for (int k = 0; k < 24; k++)
        begin
            send_cmd(calc_op_e'(3'(k % 6)), 16'($random(seed)));
        end
        idle(30);
        assert (res_val_o === 1'b0)
        else
        begin
            $display("ERROR at %0t: res_val_o expected 0 actual %b", $time, res_val_o);
            errors++;
        end
        send_cmd(OP_EMIT, '0);
        finish_test("long run without emit");

        start_test();
        rdy_mode = 1;
        idle(2);
        for (int k = 0; k < 60 && filled == 0; k++)
        begin
            if (!cmd_rdy_o)
            begin
                filled = 1;
            end
            else
            begin
                send_cmd((k % 2 == 1) ? OP_EMIT : OP_ADD, 16'(k + 1));
                idle(1);
            end
        end
        assert (filled == 1)
        else
        begin
            $display("cmd_rdy_o never fell while results were held back");
            errors++;
        end
        rdy_mode = 0;
        finish_test("back-pressure");

        start_test();
        rdy_mode = 2;
        for (int k = 0; k < 300; k++)
        begin
            send_cmd(calc_op_e'(3'($random(seed))), 16'($random(seed)));
            if (($random(seed) & 3) == 0)
            begin
                idle(1 + ($random(seed) & 3));
            end
        end
        finish_test("random stream");
        rdy_mode = 0;

        $display("tests run %0d, failed %0d, results %0d, emits %0d, errors %0d",
                 tests_run, tests_failed, results, emits, total_errors());
        if (total_errors() == 0)
        begin
            $display("test passed");
        end
        else
        begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+common
common/calc_pkg.sv
rtl/fifo/fifo_mod.sv
rtl/calc_acc_unit.sv
rtl/calc_ctrl.sv
rtl/stream_calc_top.sv
test/stream_calc_props.sv
test/tb_stream_calc.sv
